//--- src.f
cpuPkg.sv
fetchUnit.sv
decodeControl.sv
registerFile.sv
executeAlu.sv
memWriteback.sv
singleCpu.sv
tbSingleCpu.sv

//--- run.sh
#!/bin/sh
# Build and run the single-cycle CPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -f src.f --top-module tbSingleCpu -o tbSingleCpu
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tbSingleCpu > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$logFile"; then
    exit 0
else
    echo "Pass message not found in $logFile"
    exit 1
fi

//--- tbSingleCpu.sv
`timescale 1ns/10ps
`default_nettype none

module tbSingleCpu;

    localparam int tableLen    = 25;
    localparam int randLen     = 20;
    localparam int resetCycles = 2;
    localparam int clkPeriod   = 4;
    localparam int marginNs    = 100;
    // Load, reset hold and run of both programs
    localparam int timeoutNs =
        (2 * (tableLen + randLen) + 2 * (resetCycles + 1)) * clkPeriod + marginNs;

    localparam logic [6:0] opImmCode  = 7'b0010011;
    localparam logic [6:0] opLoadCode = 7'b0000011;

    typedef struct packed {
        logic [31:0] inst;
        logic        regWrite;
        logic [4:0]  rd;
        logic [31:0] wbData;
        logic        memWrite;
        logic [31:0] memAddr;
        logic [31:0] memData;
    } stepT;

    typedef struct packed {
        logic [31:0] inst;
        logic        isImm;
        logic [2:0]  f3;
        logic        alt;  // SUB or SRA form
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
    } randOpT;

    logic           CLK;
    logic           RST;
    logic           progWe;
    logic [5:0]     progAddr;
    logic [31:0]    progData;
    cpuPkg::retireT retire;

    stepT        steps [tableLen];
    randOpT      randOps [randLen];
    logic [31:0] progWords [64];
    logic [31:0] refRegs [32];  // Reference register model
    logic [31:0] rngState;
    int          errorCount;

    singleCpu uut (
        .CLK      (CLK),
        .RST      (RST),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .retire   (retire)
    );

    always #(clkPeriod / 2) CLK = ~CLK;

    function automatic logic [31:0] rType(input logic alt, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opcode);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};  // SW
    endfunction

    function automatic stepT mkStep(input logic [31:0] inst, input logic rw,
                                    input logic [4:0] rd, input logic [31:0] wb,
                                    input logic mw, input logic [31:0] addr,
                                    input logic [31:0] data);
        return '{inst, rw, rd, wb, mw, addr, data};
    endfunction

    // Non-store step with the memory fields left clear
    function automatic stepT regStep(input logic [31:0] inst, input logic rw,
                                     input logic [4:0] rd, input logic [31:0] wb);
        return mkStep(inst, rw, rd, wb, 1'b0, '0, '0);
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected result by funct3 with alt picking SUB and SRA
    function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        logic [31:0] res;
        case (f3)
            3'b000:  res = alt ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = (a[31] != b[31]) ? {31'b0, a[31]} : ((a < b) ? 32'd1 : 32'd0);
            3'b011:  res = (a < b) ? 32'd1 : 32'd0;
            3'b100:  res = a ^ b;
            3'b101: begin
                if (alt)  // Sign bits fill from the top
                    res = (a >> b[4:0]) | (a[31] ? ~(32'hFFFFFFFF >> b[4:0]) : 32'h0);
                else
                    res = a >> b[4:0];
            end
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        errorCount++;
        $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    // Holds RST high while the words go in, then releases it on a falling edge
    task automatic loadProgram(input int count);
        @(negedge CLK);
        RST = 1'b1;
        for (int i = 0; i < count; i++) begin
            progWe   = 1'b1;
            progAddr = 6'(i);
            progData = progWords[i];
            @(negedge CLK);
        end
        progWe = 1'b0;
        repeat (resetCycles) @(negedge CLK);
        if (retire.valid !== 1'b0)  // Record cleared by reset
            reportMismatch("retire.valid", 32'd0, {31'b0, retire.valid});
        RST = 1'b0;
    endtask

    task automatic checkHeader(input int k, input logic [31:0] word);
        if (retire.valid !== 1'b1)
            reportMismatch("retire.valid", 32'd1, {31'b0, retire.valid});
        if (retire.pc !== 32'(k * 4))
            reportMismatch("retire.pc", 32'(k * 4), retire.pc);
        if (retire.inst !== word)
            reportMismatch("retire.inst", word, retire.inst);
    endtask

    task automatic buildTable();
        steps[0]  = regStep(iType(12'hFFB, 5'd0, 3'b000, 5'd1, opImmCode), 1, 5'd1, 32'hFFFFFFFB);
        steps[1]  = regStep(iType(12'h003, 5'd0, 3'b000, 5'd2, opImmCode), 1, 5'd2, 32'h3);
        steps[2]  = regStep(rType(1, 5'd2, 5'd1, 3'b000, 5'd3), 1, 5'd3, 32'hFFFFFFF8);  // SUB
        steps[3]  = regStep(rType(0, 5'd2, 5'd1, 3'b010, 5'd4), 1, 5'd4, 32'h1);  // SLT
        steps[4]  = regStep(rType(0, 5'd2, 5'd1, 3'b011, 5'd5), 1, 5'd5, 32'h0);  // SLTU
        steps[5]  = regStep(rType(1, 5'd2, 5'd1, 3'b101, 5'd6), 1, 5'd6, 32'hFFFFFFFF);
        steps[6]  = regStep(rType(0, 5'd2, 5'd1, 3'b101, 5'd7), 1, 5'd7, 32'h1FFFFFFF);
        steps[7]  = regStep(iType(12'd35, 5'd0, 3'b000, 5'd8, opImmCode), 1, 5'd8, 32'h23);
        steps[8]  = regStep(rType(0, 5'd8, 5'd2, 3'b001, 5'd9), 1, 5'd9, 32'h18);  // 35 acts as 3
        steps[9]  = regStep(iType(12'h401, 5'd1, 3'b101, 5'd10, opImmCode), 1, 5'd10, 32'hFFFFFFFD);
        steps[10] = regStep(iType(12'h001, 5'd1, 3'b101, 5'd11, opImmCode), 1, 5'd11, 32'h7FFFFFFD);
        steps[11] = regStep(iType(12'hFFF, 5'd2, 3'b100, 5'd12, opImmCode), 1, 5'd12, 32'hFFFFFFFC);
        steps[12] = regStep(iType(12'hFFF, 5'd2, 3'b011, 5'd13, opImmCode), 1, 5'd13, 32'h1);
        steps[13] = regStep(iType(12'hFFF, 5'd2, 3'b010, 5'd14, opImmCode), 1, 5'd14, 32'h0);
        steps[14] = regStep(iType(12'hFF0, 5'd1, 3'b111, 5'd15, opImmCode), 1, 5'd15, 32'hFFFFFFF0);
        steps[15] = regStep(iType(12'h048, 5'd0, 3'b110, 5'd16, opImmCode), 1, 5'd16, 32'h48);
        steps[16] = mkStep(sType(12'hFF8, 5'd3, 5'd16), 0, 5'd0, 0, 1, 32'h40, 32'hFFFFFFF8);
        steps[17] = regStep(iType(12'h040, 5'd0, 3'b010, 5'd17, opLoadCode), 1, 5'd17, 32'hFFFFFFF8);
        steps[18] = regStep(iType(12'd7, 5'd2, 3'b000, 5'd0, opImmCode), 0, 5'd0, 0);  // To x0
        steps[19] = regStep(rType(0, 5'd2, 5'd0, 3'b000, 5'd18), 1, 5'd18, 32'h3);
        steps[20] = regStep(32'h123459B7, 0, 5'd0, 0);  // LUI is not supported
        steps[21] = regStep(rType(0, 5'd18, 5'd19, 3'b000, 5'd20), 1, 5'd20, 32'h3);
        steps[22] = regStep(rType(0, 5'd2, 5'd1, 3'b111, 5'd21), 1, 5'd21, 32'h3);
        steps[23] = regStep(rType(0, 5'd2, 5'd1, 3'b110, 5'd22), 1, 5'd22, 32'hFFFFFFFB);
        steps[24] = regStep(rType(0, 5'd2, 5'd1, 3'b100, 5'd23), 1, 5'd23, 32'hFFFFFFF8);
    endtask

    task automatic runTable();
        stepT s;
        for (int k = 0; k < tableLen; k++) begin
            s = steps[k];
            @(negedge CLK);
            checkHeader(k, s.inst);
            if (retire.regWrite !== s.regWrite)
                reportMismatch("retire.regWrite", {31'b0, s.regWrite}, {31'b0, retire.regWrite});
            if (s.regWrite && retire.rd !== s.rd)
                reportMismatch("retire.rd", {27'b0, s.rd}, {27'b0, retire.rd});
            if (s.regWrite && retire.wbData !== s.wbData)
                reportMismatch("retire.wbData", s.wbData, retire.wbData);
            if (retire.memWrite !== s.memWrite)
                reportMismatch("retire.memWrite", {31'b0, s.memWrite}, {31'b0, retire.memWrite});
            if (s.memWrite && retire.memAddr !== s.memAddr)
                reportMismatch("retire.memAddr", s.memAddr, retire.memAddr);
            if (s.memWrite && retire.memData !== s.memData)
                reportMismatch("retire.memData", s.memData, retire.memData);
        end
    endtask

    task automatic buildRandom();
        logic [31:0] r;
        randOpT      op;
        for (int i = 0; i < randLen; i++) begin
            rngState = xorshift(rngState);
            r        = rngState;
            op.isImm = r[0];
            op.f3    = r[3:1];
            op.rd    = {2'b00, r[6:4]};  // x0..x7 so results get reused
            op.rs1   = {2'b00, r[9:7]};
            op.rs2   = {2'b00, r[12:10]};
            op.alt   = r[13] && ((op.f3 == 3'b101) || (!op.isImm && op.f3 == 3'b000));
            op.imm   = r[31:20];
            if (op.isImm && op.f3 == 3'b001)
                op.imm = {7'b0, r[24:20]};
            if (op.isImm && op.f3 == 3'b101)
                op.imm = {1'b0, op.alt, 5'b0, r[24:20]};
            if (op.isImm)
                op.inst = iType(op.imm, op.rs1, op.f3, op.rd, opImmCode);
            else
                op.inst = rType(op.alt, op.rs2, op.rs1, op.f3, op.rd);
            randOps[i] = op;
        end
    endtask

    task automatic runRandom();
        randOpT      op;
        logic [31:0] opB;
        logic [31:0] expWb;
        logic        expWrite;
        for (int i = 0; i < 32; i++)
            refRegs[i] = '0;
        for (int k = 0; k < randLen; k++) begin
            op       = randOps[k];
            opB      = op.isImm ? {{20{op.imm[11]}}, op.imm} : refRegs[op.rs2];
            expWb    = refAlu(op.f3, op.alt, refRegs[op.rs1], opB);
            expWrite = (op.rd != 5'd0);
            @(negedge CLK);
            checkHeader(k, op.inst);
            if (retire.regWrite !== expWrite)
                reportMismatch("retire.regWrite", {31'b0, expWrite}, {31'b0, retire.regWrite});
            if (expWrite && retire.rd !== op.rd)
                reportMismatch("retire.rd", {27'b0, op.rd}, {27'b0, retire.rd});
            if (expWrite && retire.wbData !== expWb)
                reportMismatch("retire.wbData", expWb, retire.wbData);
            if (retire.memWrite !== 1'b0)
                reportMismatch("retire.memWrite", 32'd0, {31'b0, retire.memWrite});
            if (expWrite)
                refRegs[op.rd] = expWb;
        end
    endtask

    initial begin
        CLK        = 1'b0;
        RST        = 1'b1;
        progWe     = 1'b0;
        progAddr   = '0;
        progData   = '0;
        errorCount = 0;
        rngState   = 32'd72527;

        buildTable();
        for (int i = 0; i < tableLen; i++)
            progWords[i] = steps[i].inst;
        loadProgram(tableLen);
        runTable();

        // Second program after a fresh reset
        buildRandom();
        for (int i = 0; i < randLen; i++)
            progWords[i] = randOps[i].inst;
        loadProgram(randLen);
        runRandom();

        $display("Checks finished with %0d errors", errorCount);
        if (errorCount == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        #(timeoutNs);
        $display("The run did not finish within %0d ns and was stopped", timeoutNs);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- singleCpu.sv
`timescale 1ns/10ps
`default_nettype none

module singleCpu (
    input  wire                      CLK,
    input  wire                      RST,
    input  wire                      progWe,
    input  wire [cpuPkg::imemAw-1:0] progAddr,
    input  wire [cpuPkg::xlen-1:0]   progData,
    output cpuPkg::retireT           retire
);

    logic [cpuPkg::xlen-1:0]  pc;
    logic [cpuPkg::xlen-1:0]  inst;
    cpuPkg::ctrlT             ctrl;
    logic [cpuPkg::xlen-1:0]  rd1;
    logic [cpuPkg::xlen-1:0]  rd2;        // Also the store data
    logic [cpuPkg::xlen-1:0]  aluResult;
    logic                     wbWe;
    logic [cpuPkg::regAw-1:0] wbRd;
    logic [cpuPkg::xlen-1:0]  wbData;

    fetchUnit fetch (
        .CLK      (CLK),
        .RST      (RST),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .pc       (pc),
        .inst     (inst)
    );

    decodeControl decode (
        .inst (inst),
        .ctrl (ctrl)
    );

    registerFile regFile (
        .CLK    (CLK),
        .RST    (RST),
        .rs1    (ctrl.rs1),
        .rs2    (ctrl.rs2),
        .rd1    (rd1),
        .rd2    (rd2),
        .wbWe   (wbWe),
        .wbRd   (wbRd),
        .wbData (wbData)
    );

    executeAlu execute (
        .ctrl      (ctrl),
        .rd1       (rd1),
        .rd2       (rd2),
        .aluResult (aluResult)
    );

    memWriteback memWb (
        .CLK       (CLK),
        .RST       (RST),
        .pc        (pc),
        .inst      (inst),
        .ctrl      (ctrl),
        .aluResult (aluResult),
        .storeData (rd2),
        .wbWe      (wbWe),
        .wbRd      (wbRd),
        .wbData    (wbData),
        .retire    (retire)
    );

endmodule

`default_nettype wire

//--- memWriteback.sv
`timescale 1ns/10ps
`default_nettype none

module memWriteback (
    input  wire                      CLK,
    input  wire                      RST,
    input  wire [cpuPkg::xlen-1:0]   pc,
    input  wire [cpuPkg::xlen-1:0]   inst,
    input  cpuPkg::ctrlT             ctrl,
    input  wire [cpuPkg::xlen-1:0]   aluResult,
    input  wire [cpuPkg::xlen-1:0]   storeData,
    output logic                     wbWe,
    output logic [cpuPkg::regAw-1:0] wbRd,
    output logic [cpuPkg::xlen-1:0]  wbData,
    output cpuPkg::retireT           retire
);

    logic [cpuPkg::xlen-1:0]   dmem [cpuPkg::dmemDepth];
    logic [cpuPkg::dmemAw-1:0] memIdx;
    logic [cpuPkg::xlen-1:0]   loadData;
    cpuPkg::retireT            retireNext;

    // Word address, wraps at dmemDepth
    assign memIdx   = aluResult[cpuPkg::dmemAw+1:2];
    assign loadData = dmem[memIdx];  // Combinational load

    // No stores while in reset; the pc 0 word may already be a SW
    always_ff @(posedge CLK) begin
        if (!RST && ctrl.memWrite) begin
            dmem[memIdx] <= storeData;
        end
    end

    // Writeback port back to the register file
    assign wbWe   = ctrl.regWrite;
    assign wbRd   = ctrl.rd;
    assign wbData = ctrl.memRead ? loadData : aluResult;

    always_comb begin
        retireNext.valid    = 1'b1;
        retireNext.pc       = pc;
        retireNext.inst     = inst;
        retireNext.regWrite = ctrl.regWrite && (ctrl.rd != '0);  // x0 write is no write
        retireNext.rd       = ctrl.rd;
        retireNext.wbData   = wbData;
        retireNext.memWrite = ctrl.memWrite;
        retireNext.memAddr  = aluResult;
        retireNext.memData  = storeData;
    end

    // Trace record, one cycle behind fetch
    always_ff @(posedge CLK) begin
        if (RST) begin
            retire.valid    <= 1'b0;
            retire.regWrite <= 1'b0;
            retire.memWrite <= 1'b0;
        end else begin
            retire <= retireNext;
        end
    end

    // Decode never sets both; checked where the record leaves the core
    noDualWrite: assert property (
        @(posedge CLK) disable iff (RST)
        !(retire.memWrite && retire.regWrite)
    ) else $error("retire record at pc %h writes both memory and register", retire.pc);

endmodule

`default_nettype wire

//--- executeAlu.sv
`timescale 1ns/10ps
`default_nettype none

module executeAlu (
    input  cpuPkg::ctrlT             ctrl,
    input  wire [cpuPkg::xlen-1:0]   rd1,
    input  wire [cpuPkg::xlen-1:0]   rd2,
    output logic [cpuPkg::xlen-1:0]  aluResult
);

    logic [cpuPkg::xlen-1:0] opA;
    logic [cpuPkg::xlen-1:0] opB;
    logic [4:0]              shamt;
    logic                    ltSigned;
    logic                    ltUnsigned;

    assign opA   = rd1;
    assign opB   = ctrl.useImm ? ctrl.imm : rd2;  // Immediate or register
    assign shamt = opB[4:0];                      // Upper bits ignored

    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;

    // Loads and stores arrive as aluAdd, giving the effective address
    always_comb begin
        case (ctrl.aluOp)
            cpuPkg::aluAdd:  aluResult = opA + opB;
            cpuPkg::aluSub:  aluResult = opA - opB;
            cpuPkg::aluSll:  aluResult = opA << shamt;
            cpuPkg::aluSlt:  aluResult = {{(cpuPkg::xlen-1){1'b0}}, ltSigned};
            cpuPkg::aluSltu: aluResult = {{(cpuPkg::xlen-1){1'b0}}, ltUnsigned};
            cpuPkg::aluXor:  aluResult = opA ^ opB;
            cpuPkg::aluSrl:  aluResult = opA >> shamt;
            cpuPkg::aluSra:  aluResult = $unsigned($signed(opA) >>> shamt);
            cpuPkg::aluOr:   aluResult = opA | opB;
            cpuPkg::aluAnd:  aluResult = opA & opB;
            default:         aluResult = opA + opB;
        endcase
    end

endmodule

`default_nettype wire

//--- registerFile.sv
`timescale 1ns/10ps
`default_nettype none

module registerFile (
    input  wire                      CLK,
    input  wire                      RST,
    input  wire [cpuPkg::regAw-1:0]  rs1,
    input  wire [cpuPkg::regAw-1:0]  rs2,
    output logic [cpuPkg::xlen-1:0]  rd1,
    output logic [cpuPkg::xlen-1:0]  rd2,
    input  wire                      wbWe,
    input  wire [cpuPkg::regAw-1:0]  wbRd,
    input  wire [cpuPkg::xlen-1:0]   wbData
);

    logic [cpuPkg::xlen-1:0] regs [cpuPkg::regCount];

    // Asynchronous read ports
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < cpuPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWe && (wbRd != '0)) begin  // x0 stays zero
            regs[wbRd] <= wbData;
        end
    end

    // x0 holds only through reset clearing it and the write filter above
    x0ReadsZero: assert property (
        @(posedge CLK) disable iff (RST)
        (rs1 == '0) |-> (rd1 == '0)
    ) else $error("x0 read returned %h", rd1);

endmodule

`default_nettype wire

//--- decodeControl.sv
`timescale 1ns/10ps
`default_nettype none

module decodeControl (
    input  wire [cpuPkg::xlen-1:0] inst,
    output cpuPkg::ctrlT           ctrl
);

    cpuPkg::opcodeE          opcode;
    logic [2:0]              funct3;
    logic                    funct7b30;  // SUB / SRA select
    logic [cpuPkg::xlen-1:0] immI;
    logic [cpuPkg::xlen-1:0] immS;

    assign opcode    = cpuPkg::opcodeE'(inst[6:0]);
    assign funct3    = inst[14:12];
    assign funct7b30 = inst[30];

    // I form for ALU immediates and loads
    assign immI = {{(cpuPkg::xlen-12){inst[31]}}, inst[31:20]};
    // S form splits the offset around rd
    assign immS = {{(cpuPkg::xlen-12){inst[31]}}, inst[31:25], inst[11:7]};

    // funct3 to ALU op
    // Bit 30 picks SUB only for register ops; ADDI has no subtract form
    function automatic cpuPkg::aluOpE aluFromFunct(
        input logic [2:0] f3,
        input logic       b30,
        input logic       isReg
    );
        cpuPkg::aluOpE op;
        case (f3)
            3'b000:  op = (isReg && b30) ? cpuPkg::aluSub : cpuPkg::aluAdd;
            3'b001:  op = cpuPkg::aluSll;
            3'b010:  op = cpuPkg::aluSlt;
            3'b011:  op = cpuPkg::aluSltu;
            3'b100:  op = cpuPkg::aluXor;
            3'b101:  op = b30 ? cpuPkg::aluSra : cpuPkg::aluSrl;  // Also for SRAI
            3'b110:  op = cpuPkg::aluOr;
            default: op = cpuPkg::aluAnd;
        endcase
        return op;
    endfunction

    always_comb begin
        // Register fields pass through whatever the opcode
        ctrl.rd  = inst[11:7];
        ctrl.rs1 = inst[19:15];
        ctrl.rs2 = inst[24:20];

        // Safe default is a no-op that still retires
        ctrl.regWrite = 1'b0;
        ctrl.memRead  = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.useImm   = 1'b0;
        ctrl.aluOp    = cpuPkg::aluAdd;
        ctrl.imm      = immI;

        case (opcode)
            cpuPkg::opReg: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluFromFunct(funct3, funct7b30, 1'b1);
            end
            cpuPkg::opImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.useImm   = 1'b1;
                ctrl.aluOp    = aluFromFunct(funct3, funct7b30, 1'b0);
            end
            cpuPkg::opLoad: begin
                ctrl.regWrite = 1'b1;  // LW only, funct3 not checked
                ctrl.memRead  = 1'b1;
                ctrl.useImm   = 1'b1;
            end
            cpuPkg::opStore: begin
                ctrl.memWrite = 1'b1;
                ctrl.useImm   = 1'b1;
                ctrl.imm      = immS;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- fetchUnit.sv
`timescale 1ns/10ps
`default_nettype none

module fetchUnit (
    input  wire                       CLK,
    input  wire                       RST,
    input  wire                       progWe,
    input  wire [cpuPkg::imemAw-1:0]  progAddr,
    input  wire [cpuPkg::xlen-1:0]    progData,
    output logic [cpuPkg::xlen-1:0]   pc,
    output logic [cpuPkg::xlen-1:0]   inst
);

    logic [cpuPkg::xlen-1:0]   imem [cpuPkg::imemDepth];  // Program store
    logic [cpuPkg::imemAw-1:0] fetchIdx;

    // Word index from the pc; upper bits dropped so fetch wraps
    assign fetchIdx = pc[cpuPkg::imemAw+1:2];

    // Asynchronous read, the whole cycle is combinational after this
    assign inst = imem[fetchIdx];

    // Program load port
    // Only honoured while the core sits in reset, so a running program
    // never sees its own instruction words change under it
    always_ff @(posedge CLK) begin
        if (RST && progWe) begin
            imem[progAddr] <= progData;
        end
    end

    // Straight-line pc, one instruction per edge
    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= '0;
        end else begin
            pc <= pc + cpuPkg::pcStep;
        end
    end

    // Word fetch only
    pcAligned: assert property (
        @(posedge CLK) disable iff (RST)
        pc[1:0] == 2'b00
    ) else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

//--- cpuPkg.sv
`default_nettype none

package cpuPkg;

    // Datapath and storage sizes
    localparam int xlen      = 32;  // One word
    localparam int imemDepth = 64;  // Instruction words
    localparam int dmemDepth = 64;  // Data words
    localparam int imemAw    = $clog2(imemDepth);
    localparam int dmemAw    = $clog2(dmemDepth);
    localparam int regCount  = 32;
    localparam int regAw     = $clog2(regCount);

    localparam logic [xlen-1:0] pcStep = 4;  // Fixed fetch advance

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        opReg   = 7'b0110011,
        opImm   = 7'b0010011,
        opLoad  = 7'b0000011,
        opStore = 7'b0100011
    } opcodeE;

    // Encoded as {inst[30], funct3} so R-type maps one to one
    typedef enum logic [3:0] {
        aluAdd  = 4'b0000,
        aluSll  = 4'b0001,
        aluSlt  = 4'b0010,
        aluSltu = 4'b0011,
        aluXor  = 4'b0100,
        aluSrl  = 4'b0101,
        aluOr   = 4'b0110,
        aluAnd  = 4'b0111,
        aluSub  = 4'b1000,
        aluSra  = 4'b1101
    } aluOpE;

    // Decoded control word for one instruction
    typedef struct packed {
        logic             regWrite;
        logic             memRead;
        logic             memWrite;
        logic             useImm;  // Second operand from imm
        aluOpE            aluOp;
        logic [regAw-1:0] rd;
        logic [regAw-1:0] rs1;
        logic [regAw-1:0] rs2;
        logic [xlen-1:0]  imm;     // Already sign-extended
    } ctrlT;

    // One record per retired instruction
    typedef struct packed {
        logic             valid;
        logic [xlen-1:0]  pc;
        logic [xlen-1:0]  inst;
        logic             regWrite;  // Low for x0 destination
        logic [regAw-1:0] rd;
        logic [xlen-1:0]  wbData;
        logic             memWrite;
        logic [xlen-1:0]  memAddr;
        logic [xlen-1:0]  memData;
    } retireT;

endpackage

`default_nettype wire
